// File: all.f
vga_pkg.sv
pixelbuff.sv
sync_gen.sv
vga_bus_master.sv
vga_slave_regs.sv
pixel_path.sv
vga_module.sv
tb_bus_mem.sv
tb_vga.sv

// File: pixel_path.sv
module pixel_path (
	input logic clk25MHz,
	input logic reset,
	input vga_pkg::screen_pos_t pos,
	input logic hsync_raw,
	input logic vsync_raw,
	input vga_pkg::buf_wr_t buf_wr,
	output vga_pkg::pixel_t rgb,
	output logic hsync,
	output logic vsync
);

	vga_pkg::buf_rd_t rd;
	vga_pkg::pix_pair_t buf0_out;
	vga_pkg::pix_pair_t buf1_out;
	vga_pkg::pix_pair_t pair;
	vga_pkg::pixel_t pixel;
	logic buf_sel_q;
	logic byte_sel_q;
	logic active_q;

	assign rd.addr = pos.col[4:1]; // word within segment
	assign rd.byte_sel = pos.col[0]; // odd column takes hi byte
	assign rd.buf_sel = pos.col[5]; // segment parity

	pixelbuff buffer0 (
		.clk25MHz(clk25MHz),
		.we(buf_wr.we0),
		.write_address(buf_wr.addr),
		.read_address(rd.addr),
		.data_in(buf_wr.data),
		.data_out(buf0_out)
	);

	pixelbuff buffer1 (
		.clk25MHz(clk25MHz),
		.we(buf_wr.we1),
		.write_address(buf_wr.addr),
		.read_address(rd.addr),
		.data_in(buf_wr.data),
		.data_out(buf1_out)
	);

	// selects ride along with the registered read
	always_ff @(posedge clk25MHz) begin
		buf_sel_q <= rd.buf_sel;
		byte_sel_q <= rd.byte_sel;
	end

	always_ff @(posedge clk25MHz) begin
		if (reset) begin
			active_q <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			active_q <= pos.active;
			hsync <= hsync_raw; // same delay as the buffer read
			vsync <= vsync_raw;
		end
	end

	assign pair = buf_sel_q ? buf1_out : buf0_out;
	assign pixel = byte_sel_q ? pair.hi : pair.lo;
	assign rgb = active_q ? pixel : '0; // black in blanking

endmodule

// File: pixelbuff.sv
module pixelbuff (
	input logic clk25MHz,
	input logic we,
	input logic [3:0] write_address,
	input logic [3:0] read_address,
	input vga_pkg::pix_pair_t data_in,
	output vga_pkg::pix_pair_t data_out
);

	vga_pkg::pix_pair_t mem [vga_pkg::BURST_LEN]; // one segment, 32 pixels

	always_ff @(posedge clk25MHz) begin
		if (we) begin
			mem[write_address] <= data_in;
		end
		data_out <= mem[read_address]; // registered read, one cycle latency
	end

endmodule

// File: sync_gen.sv
module sync_gen #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic clk25MHz,
	input logic reset,
	output vga_pkg::screen_pos_t pos,
	output logic hsync,
	output logic vsync
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT; // line: active, front, sync, back
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

	logic [10:0] col;
	logic [10:0] row;
	logic line_end;
	logic frame_end;

	assign line_end = (col == 11'(H_TOTAL - 1));
	assign frame_end = (row == 11'(V_TOTAL - 1));

	always_ff @(posedge clk25MHz) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (line_end) begin
			col <= '0;
			if (frame_end) begin
				row <= '0;
			end else begin
				row <= row + 11'd1; // advance one line
			end
		end else begin
			col <= col + 11'd1;
		end
	end

	assign pos.row = row;
	assign pos.col = col;
	assign pos.active = (col < 11'(H_ACTIVE)) && (row < 11'(V_ACTIVE));

	// active low during the sync window only
	assign hsync = !((col >= 11'(H_SYNC_START)) && (col < 11'(H_SYNC_START + H_SYNC)));
	assign vsync = !((row >= 11'(V_SYNC_START)) && (row < 11'(V_SYNC_START + V_SYNC)));

endmodule

// File: tb_bus_mem.sv
module tb_bus_mem (
	input logic clk,
	input logic bus_req,
	input vga_pkg::bus_word_t bus_addr,
	input logic stall_en, // random ack delay and wait cycles
	output logic ack,
	output logic wait_out,
	output vga_pkg::bus_word_t data,
	output int words // words delivered in the current burst
);
	timeunit 1ns;
	timeprecision 100ps;

	function automatic vga_pkg::bus_word_t mem_word(vga_pkg::bus_word_t a);
		return {16'h0000, a[7:0] ^ 8'hff, a[7:0]}; // hi, lo
	endfunction

	initial begin
		int phase; // 0 idle, 1 ack delay, 2 transfer
		int delay;
		int waits;
		vga_pkg::bus_word_t base;
		void'($urandom(87)); // repeatable stall pattern
		phase = 0;
		ack = 1'b0;
		wait_out = 1'b1;
		data = '0;
		words = 0;
		forever begin
			@(posedge clk);
			#2;
			ack = 1'b0;
			wait_out = 1'b1;
			if (phase == 2) begin
				if (stall_en && waits < 4 && $urandom_range(3, 0) == 0) begin
					waits++; // hold off this word
				end else begin
					wait_out = 1'b0;
					data = mem_word(base + vga_pkg::bus_word_t'(words));
					words++;
					if (words == vga_pkg::BURST_LEN) phase = 0;
				end
			end else begin
				if (phase == 0 && bus_req) begin
					delay = stall_en ? $urandom_range(3, 0) : 0;
					phase = 1;
				end
				if (phase == 1) begin
					if (delay == 0) begin
						ack = 1'b1; // grant, words from next cycle
						base = bus_addr;
						words = 0;
						waits = 0;
						phase = 2;
					end else begin
						delay--;
					end
				end
			end
		end
	end

endmodule

// File: tb_vga.sv
module tb_vga;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int H_ACTIVE = 64;
	localparam int H_FRONT = 4;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 8;
	localparam int V_ACTIVE = 3;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 1;
	localparam int V_BACK = 1;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam vga_pkg::ctrl_t READ_CTRL = 8'h10; // length 16, bit 0 low for read

	logic clk;
	logic reset;
	logic slave_en;
	logic addr_phase;
	logic stall_en;
	logic prev_req;
	logic mem_ack;
	logic mem_wait;
	logic hsync;
	logic vsync;
	logic bus_req;
	vga_pkg::bus_word_t slave_data;
	vga_pkg::bus_word_t mem_data;
	vga_pkg::bus_word_t bus_in;
	vga_pkg::bus_word_t bus_out;
	vga_pkg::ctrl_t ctrl_in;
	vga_pkg::ctrl_t ctrl_out;
	vga_pkg::pixel_t rgb;
	int mem_words;
	int mismatches;
	int other_errs;

	assign bus_in = slave_en ? slave_data : mem_data; // slave writes own the bus
	assign ctrl_in = {6'b0, addr_phase, mem_wait};

	vga_module #(.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)) uut (
		.clk25MHz(clk), .reset(reset), .bus_master_ack(mem_ack), .bus_slave_en(slave_en),
		.bus_in(bus_in), .ctrl_in(ctrl_in), .rgb(rgb), .hsync(hsync), .vsync(vsync),
		.bus_req(bus_req), .ctrl_out(ctrl_out), .bus_out(bus_out)
	);

	tb_bus_mem mem (.clk(clk), .bus_req(bus_req), .bus_addr(bus_out), .stall_en(stall_en),
		.ack(mem_ack), .wait_out(mem_wait), .data(mem_data), .words(mem_words));

	always #20 clk = ~clk;

	task automatic check_pixel(string name, vga_pkg::pixel_t got, vga_pkg::pixel_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_word(string name, vga_pkg::bus_word_t got, vga_pkg::bus_word_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_ctrl(string name, vga_pkg::ctrl_t got, vga_pkg::ctrl_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	function automatic logic pick(int sel);
		return (sel == 0) ? hsync : (sel == 1) ? vsync : bus_req;
	endfunction

	// sampled at negedge, returns in the first cycle at the new level
	task automatic wait_edge(int sel, logic to, string what);
		logic prev;
		int n;
		prev = pick(sel);
		for (n = 0; n < 2 * FRAME_CYCLES; n++) begin
			@(negedge clk);
			if (pick(sel) === to && prev !== to) return;
			prev = pick(sel);
		end
		$display("error at %0t: timed out waiting for %s", $time, what);
		other_errs++;
	endtask

	task automatic measure_sync(int sel, int exp_low, int exp_period, string name);
		int low;
		int period;
		int n;
		logic seen_high;
		wait_edge(sel, 1'b0, {name, " fall"});
		low = 1;
		period = 1;
		seen_high = 1'b0;
		for (n = 0; n < 2 * FRAME_CYCLES; n++) begin
			@(negedge clk);
			if (pick(sel) == 1'b0 && seen_high) break;
			if (pick(sel) == 1'b1) seen_high = 1'b1;
			else if (!seen_high) low++;
			period++;
		end
		check_word({name, " low cycles"}, 32'(low), 32'(exp_low));
		check_word({name, " period cycles"}, 32'(period), 32'(exp_period));
	endtask

	task automatic write_reg(logic [15:0] idx, vga_pkg::bus_word_t val);
		int n;
		for (n = 0; n < FRAME_CYCLES; n++) begin
			@(posedge clk);
			#2;
			if (!bus_req) break; // keep bus_in free during a burst
		end
		if (bus_req) begin
			$display("error at %0t: bus never idle for register write", $time);
			other_errs++;
		end
		slave_en = 1'b1;
		addr_phase = 1'b1;
		slave_data = 32'(idx);
		@(posedge clk);
		#2;
		addr_phase = 1'b0;
		slave_data = val;
		@(posedge clk);
		#2;
		slave_en = 1'b0;
		slave_data = '0;
	endtask

	function automatic vga_pkg::pixel_t expected_pixel(vga_pkg::bus_word_t base,
		vga_pkg::bus_word_t stride, int row, int col);
		vga_pkg::bus_word_t a;
		a = base + 32'(row) * stride + 32'(col / 2);
		return (col % 2) ? (a[7:0] ^ 8'hff) : a[7:0];
	endfunction

	// request order from row 0 col 0 on, row 0 seg 0 comes at the end for the next frame
	task automatic check_addrs(vga_pkg::bus_word_t base, vga_pkg::bus_word_t stride);
		int rows [6] = '{0, 1, 1, 2, 2, 0};
		int segs [6] = '{1, 0, 1, 0, 1, 0};
		for (int i = 0; i < 6; i++) begin
			wait_edge(2, 1'b1, "bus_req");
			check_word("bus_out", bus_out, base + 32'(rows[i]) * stride + 32'(segs[i] * 16));
			check_ctrl("ctrl_out", ctrl_out, READ_CTRL);
		end
	endtask

	task automatic check_pixels(vga_pkg::bus_word_t base, vga_pkg::bus_word_t stride);
		for (int row = 0; row < V_ACTIVE; row++) begin
			wait_edge(0, 1'b1, "hsync rise");
			for (int i = 0; i < H_BACK; i++) begin
				check_pixel("rgb blank", rgb, '0);
				@(negedge clk);
			end
			for (int col = 0; col < H_ACTIVE; col++) begin
				check_pixel("rgb", rgb, expected_pixel(base, stride, row, col));
				@(negedge clk);
			end
			for (int i = 0; i < H_FRONT; i++) begin
				check_pixel("rgb blank", rgb, '0);
				@(negedge clk);
			end
		end
		// front porch and sync lines, ends before vsync rises again
		for (int i = 0; i < (V_FRONT + V_SYNC) * H_TOTAL; i++) begin
			check_pixel("rgb vblank", rgb, '0);
			@(negedge clk);
		end
	endtask

	task automatic run_frame(vga_pkg::bus_word_t base, vga_pkg::bus_word_t stride);
		wait_edge(1, 1'b1, "vsync rise"); // row before row 0
		fork
			check_addrs(base, stride);
			check_pixels(base, stride);
		join
	endtask

	// every burst must keep bus_req up through its 16th word
	always @(negedge clk) begin
		if (prev_req && !bus_req) check_word("words per burst", 32'(mem_words), 32'd16);
		prev_req <= bus_req;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		slave_en = 1'b0;
		addr_phase = 1'b0;
		slave_data = '0;
		stall_en = 1'b0;
		prev_req = 1'b0;
		mismatches = 0;
		other_errs = 0;
		for (int i = 0; i < 3; i++) begin // release after the fourth rising edge
			@(negedge clk);
			check_bit("bus_req", bus_req, 1'b0);
			check_bit("hsync", hsync, 1'b1);
			check_bit("vsync", vsync, 1'b1);
			check_pixel("rgb", rgb, '0);
		end
		@(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_bit("bus_req", bus_req, 1'b0);
		check_bit("hsync", hsync, 1'b1);
		check_bit("vsync", vsync, 1'b1);
		check_pixel("rgb", rgb, '0);
		measure_sync(0, H_SYNC, H_TOTAL, "hsync");
		measure_sync(1, V_SYNC * H_TOTAL, FRAME_CYCLES, "vsync");
		write_reg(vga_pkg::REG_FRAME_BASE, 32'h1000);
		write_reg(vga_pkg::REG_LINE_STRIDE, 32'h40);
		write_reg(16'd5, 32'hdead_beef); // unknown index, ignored
		wait_edge(1, 1'b1, "vsync rise"); // let row 0 seg 0 pick up the new base
		run_frame(32'h1000, 32'h40);
		stall_en = 1'b1;
		run_frame(32'h1000, 32'h40);
		write_reg(vga_pkg::REG_FRAME_BASE, 32'h2000);
		wait_edge(1, 1'b1, "vsync rise");
		run_frame(32'h2000, 32'h40);
		$display("errors: %0d mismatches, %0d other", mismatches, other_errs);
		if (mismatches == 0 && other_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: vga_bus_master.sv
module vga_bus_master #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
) (
	input logic clk25MHz,
	input logic reset,
	input vga_pkg::screen_pos_t pos,
	input vga_pkg::vga_regs_t regs,
	input logic bus_ack,
	input logic bus_wait,
	input vga_pkg::bus_word_t bus_in,
	output logic bus_req,
	output vga_pkg::bus_word_t bus_out,
	output vga_pkg::buf_wr_t buf_wr
);

	localparam int NUM_SEG = H_ACTIVE / vga_pkg::PIX_PER_BURST; // segments per line

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		TRANSFER
	} state_t;

	state_t state;

	logic fetch_line;
	logic fetch_seg;
	logic fetch_due;
	logic [5:0] disp_seg;
	logic [10:0] next_row;
	logic [10:0] trig_row;
	logic [5:0] trig_seg;

	logic pend_valid;
	logic [10:0] pend_row;
	logic [5:0] pend_seg;

	logic start;
	logic word_ok;
	logic last_word;
	logic cur_buf; // target buffer of the running burst
	logic [3:0] word_cnt;
	vga_pkg::bus_word_t burst_addr;

	assign disp_seg = pos.col[10:5]; // 32 pixels per segment

	// first hblank cycle of an active line, next row segment 0
	// last active line wraps to row 0, fetched through vertical blanking
	assign fetch_line = (pos.col == 11'(H_ACTIVE)) && (pos.row < 11'(V_ACTIVE));
	assign next_row = (pos.row == 11'(V_ACTIVE - 1)) ? 11'd0 : pos.row + 11'd1;

	// segment k starts on screen, prefetch k+1 into the other buffer
	assign fetch_seg = pos.active && (pos.col[4:0] == 5'd0) &&
		(disp_seg < 6'(NUM_SEG - 1));
	assign fetch_due = fetch_line || fetch_seg;
	assign trig_row = fetch_line ? next_row : pos.row;
	assign trig_seg = fetch_line ? 6'd0 : disp_seg + 6'd1;

	// base + row * stride + segment * 16, sampled when the burst starts
	assign burst_addr = regs.frame_base +
		vga_pkg::bus_word_t'(pend_row) * regs.line_stride +
		vga_pkg::bus_word_t'({pend_seg, 4'b0000});

	assign start = (state == IDLE) && pend_valid;
	assign word_ok = (state == TRANSFER) && !bus_wait; // one word per non-wait cycle
	assign last_word = word_ok && (word_cnt == 4'(vga_pkg::BURST_LEN - 1));

	always_ff @(posedge clk25MHz) begin
		if (reset) begin
			state <= IDLE;
			pend_valid <= 1'b0;
			word_cnt <= '0;
		end else begin
			case (state)
				IDLE: if (pend_valid) state <= REQUEST;
				REQUEST: if (bus_ack) state <= TRANSFER; // words start next cycle
				TRANSFER: if (last_word) state <= IDLE; // req drops after 16th word
				default: state <= IDLE;
			endcase
			if (fetch_due) begin
				pend_valid <= 1'b1; // newer trigger replaces an unserved one
			end else if (start) begin
				pend_valid <= 1'b0;
			end
			if (start) begin
				word_cnt <= '0;
			end else if (word_ok) begin
				word_cnt <= word_cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge clk25MHz) begin
		if (fetch_due) begin
			pend_row <= trig_row;
			pend_seg <= trig_seg;
		end
		if (start) begin
			bus_out <= burst_addr; // held for the whole burst
			cur_buf <= pend_seg[0]; // segment k lives in buffer k mod 2
		end
	end

	assign bus_req = (state != IDLE);

	assign buf_wr.we0 = word_ok && !cur_buf;
	assign buf_wr.we1 = word_ok && cur_buf;
	assign buf_wr.addr = word_cnt;
	assign buf_wr.data = vga_pkg::pix_pair_t'(bus_in[15:0]);

endmodule

// File: vga_module.sv
module vga_module #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic clk25MHz,
	input logic reset,
	input logic bus_master_ack,
	input logic bus_slave_en,
	input vga_pkg::bus_word_t bus_in,
	input vga_pkg::ctrl_t ctrl_in,
	output vga_pkg::pixel_t rgb,
	output logic hsync,
	output logic vsync,
	output logic bus_req,
	output vga_pkg::ctrl_t ctrl_out,
	output vga_pkg::bus_word_t bus_out
);

	vga_pkg::screen_pos_t pos;
	vga_pkg::vga_regs_t regs;
	vga_pkg::buf_wr_t buf_wr;
	logic hsync_raw;
	logic vsync_raw;

	assign ctrl_out = vga_pkg::CTRL_READ_BURST; // always a 16 word read

	sync_gen #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) sgen (
		.clk25MHz(clk25MHz),
		.reset(reset),
		.pos(pos),
		.hsync(hsync_raw),
		.vsync(vsync_raw)
	);

	vga_bus_master #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE)
	) bus_master (
		.clk25MHz(clk25MHz),
		.reset(reset),
		.pos(pos),
		.regs(regs),
		.bus_ack(bus_master_ack),
		.bus_wait(ctrl_in[0]), // memory not ready this cycle
		.bus_in(bus_in),
		.bus_req(bus_req),
		.bus_out(bus_out),
		.buf_wr(buf_wr)
	);

	vga_slave_regs slave_regs (
		.clk25MHz(clk25MHz),
		.reset(reset),
		.slave_en(bus_slave_en),
		.addr_phase(ctrl_in[1]), // high on the index cycle
		.bus_in(bus_in),
		.regs(regs)
	);

	pixel_path ppath (
		.clk25MHz(clk25MHz),
		.reset(reset),
		.pos(pos),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw),
		.buf_wr(buf_wr),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync)
	);

endmodule

// File: vga_pkg.sv
package vga_pkg;

	localparam int COLOR_DEPTH = 8;
	localparam int BUS_WIDTH = 32;
	localparam int CTRL_WIDTH = 8;

	localparam int BURST_LEN = 16; // words per burst = buffer depth
	localparam int PIX_PER_BURST = 2 * BURST_LEN; // two pixels per word

	typedef logic [COLOR_DEPTH-1:0] pixel_t;
	typedef logic [BUS_WIDTH-1:0] bus_word_t;
	typedef logic [CTRL_WIDTH-1:0] ctrl_t;

	// burst length 16 in the upper nibble, bit 0 low for read
	localparam ctrl_t CTRL_READ_BURST = 8'b0001_0000;

	// slave register indices
	localparam logic [15:0] REG_FRAME_BASE = 16'd0;
	localparam logic [15:0] REG_LINE_STRIDE = 16'd1;

	// lo pixel sits in bits 7:0 of the memory word
	typedef struct packed {
		pixel_t hi; // odd column
		pixel_t lo; // even column
	} pix_pair_t;

	typedef struct packed {
		logic [10:0] row;
		logic [10:0] col;
		logic active; // inside both active ranges
	} screen_pos_t;

	typedef struct packed {
		bus_word_t frame_base; // word address of row 0
		bus_word_t line_stride; // words per row
	} vga_regs_t;

	typedef struct packed {
		logic we0;
		logic we1;
		logic [3:0] addr; // word index in burst
		pix_pair_t data;
	} buf_wr_t;

	typedef struct packed {
		logic buf_sel;
		logic byte_sel;
		logic [3:0] addr;
	} buf_rd_t;

endpackage

// File: vga_slave_regs.sv
module vga_slave_regs (
	input logic clk25MHz,
	input logic reset,
	input logic slave_en,
	input logic addr_phase,
	input vga_pkg::bus_word_t bus_in,
	output vga_pkg::vga_regs_t regs
);

	logic [15:0] reg_idx; // index from the last address phase
	logic addr_we;
	logic data_we;
	logic base_we;
	logic stride_we;

	assign addr_we = slave_en && addr_phase;
	assign data_we = slave_en && !addr_phase;

	// per-register enables, other indices fall through
	assign base_we = data_we && (reg_idx == vga_pkg::REG_FRAME_BASE);
	assign stride_we = data_we && (reg_idx == vga_pkg::REG_LINE_STRIDE);

	always_ff @(posedge clk25MHz) begin
		if (reset) begin
			reg_idx <= '0;
		end else if (addr_we) begin
			reg_idx <= bus_in[15:0];
		end
	end

	always_ff @(posedge clk25MHz) begin
		if (reset) begin
			regs.frame_base <= '0;
		end else if (base_we) begin
			regs.frame_base <= bus_in;
		end
	end

	always_ff @(posedge clk25MHz) begin
		if (reset) begin
			regs.line_stride <= '0;
		end else if (stride_we) begin
			regs.line_stride <= bus_in; // stride in words
		end
	end

endmodule
